//--- include/rf_defines.svh
`ifndef RF_DEFINES_SVH
`define RF_DEFINES_SVH

// register file geometry.
`define RF_DATA_W 32
`define RF_ENTRIES 32
`define RF_ADDR_W 5

// word address width seen on the wishbone port.
`define WB_ADR_W 7

// word addresses 0 to 31 map straight onto the registers.
// the two control words sit above them.
`define ADR_INSTR 7'h40
`define ADR_STATUS 7'h41

`endif

//--- source/rf_pkg.sv
`include "rf_defines.svh"

package rf_pkg;

	// values 10 to 15 are reserved and execute as no-ops.
	typedef enum logic [3:0] {
		OP_ADD = 4'd0,
		OP_SUB = 4'd1,
		OP_SLT = 4'd2,
		OP_SLTU = 4'd3,
		OP_AND = 4'd4,
		OP_OR = 4'd5,
		OP_XOR = 4'd6,
		OP_SLL = 4'd7,
		OP_SRL = 4'd8,
		OP_SRA = 4'd9
	} opcode_e;

	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_EXEC = 2'd1,
		ST_ACK = 2'd2
	} ctrl_state_e;

	// taken from the low 19 bits of an instruction write.
	typedef struct packed {
		opcode_e opcode;
		logic [`RF_ADDR_W-1:0] rd;
		logic [`RF_ADDR_W-1:0] rs1;
		logic [`RF_ADDR_W-1:0] rs2;
	} instr_t;

	typedef struct packed {
		logic hit;
		logic [`RF_DATA_W-1:0] data;
	} unit_result_t;

	typedef struct packed {
		logic en;
		logic [`RF_ADDR_W-1:0] addr;
		logic [`RF_DATA_W-1:0] data;
	} rf_write_t;

endpackage

//--- source/regfile_2r1w_zero.sv
`timescale 1ns/10ps

`include "rf_defines.svh"

module regfile_2r1w_zero #(
	parameter int data_nbits = 32,
	parameter int num_entries = 32
) (
	input  logic clk,
	input  logic [`RF_ADDR_W-1:0] read_addr0,
	input  logic [`RF_ADDR_W-1:0] read_addr1,
	output logic [data_nbits-1:0] read_data0,
	output logic [data_nbits-1:0] read_data1,
	input  rf_pkg::rf_write_t wr
);

	logic [data_nbits-1:0] rfile [num_entries];

	// contents are undefined until the host or an instruction writes them.
	always_ff @(posedge clk) begin
		if (wr.en) begin
			rfile[wr.addr] <= wr.data;
		end
	end

	// entry 0 may hold anything, the read ports hide it.
	assign read_data0 = (read_addr0 == '0) ? '0 : rfile[read_addr0];
	assign read_data1 = (read_addr1 == '0) ? '0 : rfile[read_addr1];

endmodule

//--- source/arith_unit.sv
`timescale 1ns/10ps

`include "rf_defines.svh"

module arith_unit (
	input  rf_pkg::opcode_e opcode,
	input  logic [`RF_DATA_W-1:0] op_a,
	input  logic [`RF_DATA_W-1:0] op_b,
	output rf_pkg::unit_result_t result
);

	logic [`RF_DATA_W-1:0] sum;
	logic [`RF_DATA_W-1:0] diff;
	logic lt_signed;
	logic lt_unsigned;

	assign sum = op_a + op_b;
	assign diff = op_a - op_b;
	assign lt_signed = $signed(op_a) < $signed(op_b);
	assign lt_unsigned = op_a < op_b;

	always_comb begin
		result.hit = 1'b1;
		case (opcode)
			rf_pkg::OP_ADD: begin
				result.data = sum;
			end
			rf_pkg::OP_SUB: begin
				result.data = diff;
			end
			rf_pkg::OP_SLT: begin
				result.data = {{(`RF_DATA_W-1){1'b0}}, lt_signed};
			end
			rf_pkg::OP_SLTU: begin
				result.data = {{(`RF_DATA_W-1){1'b0}}, lt_unsigned};
			end
			default: begin
				// not one of ours, the other unit or the reserved path takes it.
				result.hit = 1'b0;
				result.data = '0;
			end
		endcase
	end

endmodule

//--- source/logic_shift_unit.sv
`timescale 1ns/10ps

`include "rf_defines.svh"

module logic_shift_unit (
	input  rf_pkg::opcode_e opcode,
	input  logic [`RF_DATA_W-1:0] op_a,
	input  logic [`RF_DATA_W-1:0] op_b,
	output rf_pkg::unit_result_t result
);

	// only the low five bits of the second operand give the shift amount.
	logic [4:0] shamt;
	logic [`RF_DATA_W-1:0] sra_out;

	assign shamt = op_b[4:0];
	assign sra_out = $signed(op_a) >>> shamt;

	always_comb begin
		result.hit = 1'b1;
		case (opcode)
			rf_pkg::OP_AND: begin
				result.data = op_a & op_b;
			end
			rf_pkg::OP_OR: begin
				result.data = op_a | op_b;
			end
			rf_pkg::OP_XOR: begin
				result.data = op_a ^ op_b;
			end
			rf_pkg::OP_SLL: begin
				result.data = op_a << shamt;
			end
			rf_pkg::OP_SRL: begin
				result.data = op_a >> shamt;
			end
			rf_pkg::OP_SRA: begin
				result.data = sra_out;
			end
			default: begin
				result.hit = 1'b0;
				result.data = '0;
			end
		endcase
	end

endmodule

//--- source/writeback_select.sv
`timescale 1ns/10ps

`include "rf_defines.svh"

module writeback_select (
	input  logic clk,
	input  logic reset,
	input  logic exec_fire,
	input  logic [`RF_ADDR_W-1:0] rd,
	input  rf_pkg::unit_result_t arith,
	input  rf_pkg::unit_result_t logic_shift,
	input  rf_pkg::rf_write_t host_write,
	output rf_pkg::rf_write_t wr,
	output logic [`RF_DATA_W-1:0] status
);

	logic any_hit;
	logic [`RF_DATA_W-1:0] exec_data;
	logic zero_flag;
	logic reserved_flag;
	logic [7:0] exec_count;

	assign any_hit = arith.hit || logic_shift.hit;
	assign exec_data = arith.hit ? arith.data : logic_shift.data;

	// the controller never raises a host write while an instruction executes.
	always_comb begin
		if (exec_fire) begin
			wr.en = any_hit;
			wr.addr = rd;
			wr.data = exec_data;
		end else begin
			wr = host_write;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			zero_flag <= 1'b0;
			reserved_flag <= 1'b0;
			exec_count <= '0;
		end else if (exec_fire) begin
			zero_flag <= any_hit && (exec_data == '0);
			reserved_flag <= !any_hit;
			if (any_hit) begin
				exec_count <= exec_count + 8'd1;
			end
		end
	end

	assign status = {16'd0, exec_count, 6'd0, reserved_flag, zero_flag};

	// the opcode ranges of the two units must stay disjoint.
	unit_hit_onehot: assert property (
		@(posedge clk) disable iff (reset)
		exec_fire |-> !(arith.hit && logic_shift.hit)
	) else $error("both execution units claimed the same opcode");

endmodule

//--- source/wb_slave_ctrl.sv
`timescale 1ns/10ps

`include "rf_defines.svh"

module wb_slave_ctrl (
	input  logic clk,
	input  logic reset,
	input  logic cyc,
	input  logic stb,
	input  logic we,
	input  logic [`WB_ADR_W-1:0] adr,
	input  logic [`RF_DATA_W-1:0] dat_w,
	output logic [`RF_DATA_W-1:0] dat_r,
	output logic ack,
	output logic [`RF_ADDR_W-1:0] read_addr0,
	output logic [`RF_ADDR_W-1:0] read_addr1,
	input  logic [`RF_DATA_W-1:0] read_data0,
	input  logic [`RF_DATA_W-1:0] status,
	output rf_pkg::instr_t instr,
	output logic exec_fire,
	output rf_pkg::rf_write_t host_write
);

	rf_pkg::ctrl_state_e state;
	logic req;
	logic accept;
	logic adr_is_reg;
	logic adr_is_instr;
	logic adr_is_status;

	assign req = cyc && stb;
	// a new request is only taken in idle, so one access is in flight at a time.
	assign accept = req && (state == rf_pkg::ST_IDLE);

	assign adr_is_reg = (adr[`WB_ADR_W-1:`RF_ADDR_W] == '0);
	assign adr_is_instr = (adr == `ADR_INSTR);
	assign adr_is_status = (adr == `ADR_STATUS);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= rf_pkg::ST_IDLE;
			ack <= 1'b0;
		end else begin
			ack <= 1'b0;
			case (state)
				rf_pkg::ST_IDLE: begin
					if (req) begin
						if (we && adr_is_instr) begin
							state <= rf_pkg::ST_EXEC;
						end else begin
							state <= rf_pkg::ST_ACK;
							ack <= 1'b1;
						end
					end
				end
				rf_pkg::ST_EXEC: begin
					// the result is written at this edge, ack follows in the next cycle.
					state <= rf_pkg::ST_ACK;
					ack <= 1'b1;
				end
				rf_pkg::ST_ACK: begin
					state <= rf_pkg::ST_IDLE;
				end
				default: begin
					state <= rf_pkg::ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept && we && adr_is_instr) begin
			instr <= rf_pkg::instr_t'(dat_w[$bits(rf_pkg::instr_t)-1:0]);
		end
		if (accept && !we) begin
			if (adr_is_reg) begin
				dat_r <= read_data0;
			end else if (adr_is_status) begin
				dat_r <= status;
			end else begin
				dat_r <= '0;
			end
		end
	end

	assign exec_fire = (state == rf_pkg::ST_EXEC);

	always_comb begin
		if (exec_fire) begin
			read_addr0 = instr.rs1;
			read_addr1 = instr.rs2;
		end else begin
			read_addr0 = adr[`RF_ADDR_W-1:0];
			read_addr1 = '0;
		end
	end

	// host register writes land at the same edge that accepts the request.
	assign host_write.en = accept && we && adr_is_reg;
	assign host_write.addr = adr[`RF_ADDR_W-1:0];
	assign host_write.data = dat_w;

	ack_needs_request: assert property (
		@(posedge clk) disable iff (reset)
		ack |-> (cyc && stb)
	) else $error("ack raised without an active request");

	ack_single_cycle: assert property (
		@(posedge clk) disable iff (reset)
		ack |=> !ack
	) else $error("ack held for more than one cycle");

endmodule

//--- source/rf_engine_top.sv
`timescale 1ns/10ps

`include "rf_defines.svh"

module rf_engine_top (
	input  logic clk,
	input  logic reset,
	input  logic cyc,
	input  logic stb,
	input  logic we,
	input  logic [`WB_ADR_W-1:0] adr,
	input  logic [`RF_DATA_W-1:0] dat_w,
	output logic [`RF_DATA_W-1:0] dat_r,
	output logic ack
);

	logic [`RF_ADDR_W-1:0] read_addr0;
	logic [`RF_ADDR_W-1:0] read_addr1;
	logic [`RF_DATA_W-1:0] read_data0;
	logic [`RF_DATA_W-1:0] read_data1;
	logic [`RF_DATA_W-1:0] status;
	logic exec_fire;
	rf_pkg::instr_t instr;
	rf_pkg::rf_write_t host_write;
	rf_pkg::rf_write_t wr;
	rf_pkg::unit_result_t arith_result;
	rf_pkg::unit_result_t logic_shift_result;

	wb_slave_ctrl ctrl (
		.clk(clk),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.dat_r(dat_r),
		.ack(ack),
		.read_addr0(read_addr0),
		.read_addr1(read_addr1),
		.read_data0(read_data0),
		.status(status),
		.instr(instr),
		.exec_fire(exec_fire),
		.host_write(host_write)
	);

	regfile_2r1w_zero #(
		.data_nbits(`RF_DATA_W),
		.num_entries(`RF_ENTRIES)
	) rfile (
		.clk(clk),
		.read_addr0(read_addr0),
		.read_addr1(read_addr1),
		.read_data0(read_data0),
		.read_data1(read_data1),
		.wr(wr)
	);

	arith_unit alu (
		.opcode(instr.opcode),
		.op_a(read_data0),
		.op_b(read_data1),
		.result(arith_result)
	);

	logic_shift_unit lsu (
		.opcode(instr.opcode),
		.op_a(read_data0),
		.op_b(read_data1),
		.result(logic_shift_result)
	);

	writeback_select wb_sel (
		.clk(clk),
		.reset(reset),
		.exec_fire(exec_fire),
		.rd(instr.rd),
		.arith(arith_result),
		.logic_shift(logic_shift_result),
		.host_write(host_write),
		.wr(wr),
		.status(status)
	);

endmodule

//--- testbench/tb_rf_engine.sv
`timescale 1ns/10ps

`include "rf_defines.svh"

module tb_rf_engine;

	localparam int ACK_TIMEOUT = 20;

	logic clk;
	logic reset;
	logic cyc;
	logic stb;
	logic we;
	logic [`WB_ADR_W-1:0] adr;
	logic [`RF_DATA_W-1:0] dat_w;
	logic [`RF_DATA_W-1:0] dat_r;
	logic ack;

	logic [`RF_DATA_W-1:0] model_regs [`RF_ENTRIES];
	logic model_zero;
	logic model_reserved;
	logic [7:0] model_count;
	logic [31:0] rng;

	rf_engine_top DUT (
		.clk(clk),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.dat_r(dat_r),
		.ack(ack)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("Testbench failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("ERR %s expected %08h actual %08h", name, expected, actual);
		$display("Testbench failed");
		$fatal(1, "%s differs from the model", name);
	endtask

	ack_with_request: assert property (
		@(posedge clk) disable iff (reset) ack |-> (cyc && stb)
	) else stop_on_error("ack was high without cyc and stb");

	function automatic logic [31:0] next_random();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// top bit is set when the opcode writes a result.
	function automatic logic [`RF_DATA_W:0] expected_result(input logic [3:0] op,
			input logic [31:0] a, input logic [31:0] b);
		logic [4:0] sh;
		logic lt;
		logic [31:0] fill;
		sh = b[4:0];
		// signed order equals unsigned order unless the sign bits differ.
		lt = (a[31] != b[31]) ? a[31] : (a < b);
		fill = a[31] ? ~(32'hffffffff >> sh) : 32'd0;
		case (op)
			rf_pkg::OP_ADD: return {1'b1, a + b};
			rf_pkg::OP_SUB: return {1'b1, a - b};
			rf_pkg::OP_SLT: return {1'b1, 31'd0, lt};
			rf_pkg::OP_SLTU: return {1'b1, 31'd0, (a < b)};
			rf_pkg::OP_AND: return {1'b1, a & b};
			rf_pkg::OP_OR: return {1'b1, a | b};
			rf_pkg::OP_XOR: return {1'b1, a ^ b};
			rf_pkg::OP_SLL: return {1'b1, a << sh};
			rf_pkg::OP_SRL: return {1'b1, a >> sh};
			rf_pkg::OP_SRA: return {1'b1, (a >> sh) | fill};
			default: return {1'b0, 32'd0};
		endcase
	endfunction

	// cycles counts the edges after the one that samples the request.
	task automatic wait_ack(output int cycles);
		bit seen;
		seen = 1'b0;
		cycles = 0;
		@(posedge clk);
		while (!seen) begin
			@(posedge clk);
			cycles = cycles + 1;
			if (ack === 1'b1) begin
				seen = 1'b1;
			end else if (cycles >= ACK_TIMEOUT) begin
				stop_on_error("the DUT gave no ack within the timeout");
			end
		end
	endtask

	task automatic end_cycle();
		#1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		@(posedge clk);
		assert (ack === 1'b0) else report_mismatch("ack", 32'd0, {31'd0, ack});
		#1;
	endtask

	task automatic bus_write(input logic [`WB_ADR_W-1:0] addr, input logic [31:0] data,
			input int exp_lat);
		int cycles;
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b1;
		adr = addr;
		dat_w = data;
		wait_ack(cycles);
		assert (cycles == exp_lat) else report_mismatch("ack latency", 32'(exp_lat), 32'(cycles));
		end_cycle();
	endtask

	task automatic bus_read(input logic [`WB_ADR_W-1:0] addr, output logic [31:0] data);
		int cycles;
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b0;
		adr = addr;
		wait_ack(cycles);
		data = dat_r;
		assert (cycles == 1) else report_mismatch("ack latency", 32'd1, 32'(cycles));
		end_cycle();
	endtask

	task automatic write_reg(input logic [4:0] idx, input logic [31:0] v);
		bus_write({2'b00, idx}, v, 1);
		if (idx != 5'd0) begin
			model_regs[idx] = v;
		end
	endtask

	task automatic check_reg(input logic [4:0] idx);
		logic [31:0] got;
		bus_read({2'b00, idx}, got);
		assert (got === model_regs[idx])
			else report_mismatch($sformatf("dat_r r%0d", idx), model_regs[idx], got);
	endtask

	task automatic check_all_regs();
		for (int i = 0; i < `RF_ENTRIES; i++) begin
			check_reg(5'(i));
		end
	endtask

	task automatic check_status();
		logic [31:0] got;
		logic [31:0] expected;
		expected = {16'd0, model_count, 6'd0, model_reserved, model_zero};
		bus_read(`ADR_STATUS, got);
		assert (got === expected) else report_mismatch("dat_r status", expected, got);
	endtask

	task automatic run_instr(input logic [3:0] op, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [4:0] rs2);
		logic [`RF_DATA_W:0] res;
		res = expected_result(op, model_regs[rs1], model_regs[rs2]);
		bus_write(`ADR_INSTR, {13'd0, op, rd, rs1, rs2}, 2);
		if (res[`RF_DATA_W]) begin
			if (rd != 5'd0) begin
				model_regs[rd] = res[`RF_DATA_W-1:0];
			end
			model_zero = (res[`RF_DATA_W-1:0] == 32'd0);
			model_reserved = 1'b0;
			model_count = model_count + 8'd1;
		end else begin
			model_zero = 1'b0;
			model_reserved = 1'b1;
		end
		check_status();
		check_reg(rd);
	endtask

	task automatic try_pair(input logic [3:0] op, input logic [31:0] a, input logic [31:0] b);
		write_reg(5'd1, a);
		write_reg(5'd2, b);
		run_instr(op, 5'd3, 5'd1, 5'd2);
	endtask

	initial begin
		logic [31:0] a;
		logic [31:0] b;
		reset = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_w = '0;
		rng = 32'hd12b90f5;
		model_zero = 1'b0;
		model_reserved = 1'b0;
		model_count = 8'd0;
		for (int i = 0; i < `RF_ENTRIES; i++) begin
			model_regs[i] = '0;
		end
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		repeat (5) begin
			@(posedge clk);
			assert (ack === 1'b0) else report_mismatch("ack", 32'd0, {31'd0, ack});
		end
		#1;
		check_status();

		for (int i = 1; i < `RF_ENTRIES; i++) begin
			a = next_random();
			write_reg(5'(i), a);
		end
		check_all_regs();

		// a host write and an instruction both aim at register 0.
		a = next_random();
		write_reg(5'd0, a | 32'd1);
		check_reg(5'd0);
		run_instr(rf_pkg::OP_OR, 5'd0, 5'd4, 5'd5);
		check_all_regs();

		for (int op = 0; op < 4; op++) begin
			repeat (4) begin
				a = next_random();
				b = next_random();
				try_pair(4'(op), a, b);
			end
			try_pair(4'(op), a, a);
			try_pair(4'(op), 32'h80000000, 32'h00000001);
			try_pair(4'(op), 32'h00000001, 32'h80000000);
			try_pair(4'(op), 32'hffffffff, 32'hffffffff);
			try_pair(4'(op), 32'hffffffff, 32'h00000001);
			run_instr(4'(op), 5'd1, 5'd1, 5'd2);
		end

		for (int op = 4; op < 10; op++) begin
			repeat (3) begin
				a = next_random();
				b = next_random();
				try_pair(4'(op), a, b);
			end
			try_pair(4'(op), a, {b[31:5], 5'd0});
			try_pair(4'(op), a, {b[31:5], 5'd31});
			try_pair(4'(op), 32'h80000000, {b[31:5], 5'd31});
		end

		run_instr(4'd12, 5'd7, 5'd1, 5'd2);
		check_all_regs();
		run_instr(rf_pkg::OP_ADD, 5'd8, 5'd0, 5'd0);

		$display("Testbench passed");
		$finish;
	end

endmodule

//--- sim.f
+incdir+include
source/rf_pkg.sv
source/regfile_2r1w_zero.sv
source/arith_unit.sv
source/logic_shift_unit.sv
source/writeback_select.sv
source/wb_slave_ctrl.sv
source/rf_engine_top.sv
testbench/tb_rf_engine.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
# A $fatal in the testbench gives a nonzero exit status.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module tb_rf_engine -f sim.f \
	--Mdir obj_dir -o tb_rf_engine

./obj_dir/tb_rf_engine
